/* project.f */
hw/cpu_isa_pkg.sv
hw/cpu_pipe_pkg.sv
hw/alu.sv
hw/decode_unit.sv
hw/register_file.sv
hw/execute_stage.sv
hw/cpu_core.sv
dv/tb_clk_gen.sv
dv/cpu_core_tb.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := cpu_core_tb
FILELIST := project.f
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
PASS_MSG := Simulation finished: PASS
SRCS     := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/cpu_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_core_tb;

  import cpu_isa_pkg::*;
  import cpu_pipe_pkg::*;

  typedef struct packed {
    inst_t inst;
    logic  gap;
    logic  jitter;
  } row_t;

  logic  clk;
  logic  rst_n;
  logic  inst_valid;
  inst_t inst;
  wb_t   wb;

  row_t  rows[$];
  wb_t   pending[$];
  word_t ref_regs [num_regs];
  int    seed;
  int    cycle_cnt = 0;
  int    timeout_limit = 0;

  tb_clk_gen i_clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  cpu_core i_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .inst_valid (inst_valid),
    .inst       (inst),
    .wb         (wb)
  );

  function automatic inst_t r_type(
    input opcode_e op, input reg_addr_t rd, input reg_addr_t rs, input reg_addr_t rt
  );
    inst_t i;
    i = '0;
    i.opcode = op;
    i.rs = rs;
    i.rt = rt;
    i.low.r.rd = rd;
    return i;
  endfunction

  function automatic inst_t shift_type(
    input opcode_e op, input reg_addr_t rd, input reg_addr_t rt, input logic [4:0] shamt
  );
    inst_t i;
    i = r_type(op, rd, 5'd0, rt);
    i.low.r.shamt = shamt;
    return i;
  endfunction

  function automatic inst_t imm_type(
    input opcode_e op, input reg_addr_t rt, input reg_addr_t rs, input logic [15:0] imm
  );
    inst_t i;
    i = '0;
    i.opcode = op;
    i.rs = rs;
    i.rt = rt;
    i.low.imm = imm;
    return i;
  endfunction

  task automatic append(input inst_t i);
    rows.push_back('{inst: i, gap: 1'b0, jitter: 1'b0});
  endtask

  task automatic idle_row();
    rows.push_back('{inst: '0, gap: 1'b1, jitter: 1'b0});
  endtask

  task automatic after_idles(input inst_t i);
    rows.push_back('{inst: i, gap: 1'b0, jitter: 1'b1});
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////////////

  // applies one accepted instruction in program order
  function automatic wb_t model_inst(input inst_t i);
    wb_t       w;
    word_t     a;
    word_t     b;
    word_t     zimm;
    reg_addr_t dest;
    logic      writes;
    a = ref_regs[i.rs];
    b = ref_regs[i.rt];
    zimm = {16'h0000, i.low.imm};
    dest = i.low.r.rd;
    writes = 1'b1;
    w = '0;
    case (i.opcode)
      op_add:  w.data = a + b;
      op_sub:  w.data = a - b;
      op_and:  w.data = a & b;
      op_or:   w.data = a | b;
      op_xor:  w.data = a ^ b;
      op_slt:  w.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      op_sll:  w.data = b << i.low.r.shamt;
      op_srl:  w.data = b >> i.low.r.shamt;
      op_addi: w.data = a + zimm;
      op_andi: w.data = a & zimm;
      op_ori:  w.data = a | zimm;
      default: writes = 1'b0;
    endcase
    if (i.opcode inside {op_addi, op_andi, op_ori}) begin
      dest = i.rt;
    end
    if (writes && (dest != 5'd0)) begin
      w.valid = 1'b1;
      w.rd = dest;
      ref_regs[dest] = w.data;
    end else begin
      w = '0;
    end
    return w;
  endfunction

  task automatic stop_on_error();
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_wb(input wb_t actual, input wb_t expected);
    if (actual.valid !== expected.valid) begin
      $display("mismatch at %0t: wb.valid got %b expected %b",
               $time, actual.valid, expected.valid);
      stop_on_error();
    end else if (expected.valid && (actual.rd !== expected.rd)) begin
      $display("mismatch at %0t: wb.rd got %0d expected %0d",
               $time, actual.rd, expected.rd);
      stop_on_error();
    end else if (expected.valid && (actual.data !== expected.data)) begin
      $display("mismatch at %0t: wb.data got %h expected %h",
               $time, actual.data, expected.data);
      stop_on_error();
    end
  endtask

  // drives one row on the rising edge and checks wb at the falling edge
  task automatic step(input logic valid_in, input inst_t inst_in);
    wb_t expected;
    @(posedge clk);
    inst_valid <= valid_in;
    inst <= inst_in;
    expected = valid_in ? model_inst(inst_in) : '0;
    pending.push_back(expected);
    @(negedge clk);
    check_wb(wb, pending.pop_front());
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////////////////////////////////////////

  task automatic build_table();
    append(imm_type(op_addi, 5'd1, 5'd0, 16'h0005));
    append(imm_type(op_ori, 5'd2, 5'd0, 16'hfff0));
    append(imm_type(op_addi, 5'd3, 5'd0, 16'h1234));
    append(r_type(op_sub, 5'd5, 5'd0, 5'd1));
    append(r_type(op_sub, 5'd8, 5'd0, 5'd3));
    append(r_type(op_add, 5'd4, 5'd1, 5'd2));
    append(r_type(op_and, 5'd7, 5'd5, 5'd2));
    append(r_type(op_or, 5'd9, 5'd1, 5'd3));
    append(r_type(op_xor, 5'd10, 5'd5, 5'd3));
    // signed compares on negative operands
    append(r_type(op_slt, 5'd11, 5'd5, 5'd1));
    append(r_type(op_slt, 5'd12, 5'd1, 5'd5));
    append(r_type(op_slt, 5'd13, 5'd8, 5'd5));
    append(shift_type(op_sll, 5'd15, 5'd3, 5'd4));
    append(shift_type(op_srl, 5'd16, 5'd5, 5'd28));
    append(imm_type(op_addi, 5'd18, 5'd5, 16'h8000));
    append(imm_type(op_andi, 5'd19, 5'd5, 16'h8f0f));
    append(imm_type(op_ori, 5'd20, 5'd8, 16'h00ff));
    // back to back on rs, rt and both
    append(r_type(op_add, 5'd21, 5'd1, 5'd3));
    append(r_type(op_add, 5'd22, 5'd21, 5'd1));
    append(r_type(op_sub, 5'd23, 5'd3, 5'd22));
    append(r_type(op_add, 5'd24, 5'd23, 5'd23));
    append(shift_type(op_sll, 5'd25, 5'd24, 5'd3));
    // two apart, then three apart
    append(imm_type(op_addi, 5'd27, 5'd0, 16'h0077));
    idle_row();
    append(r_type(op_add, 5'd28, 5'd27, 5'd27));
    append(r_type(op_xor, 5'd29, 5'd28, 5'd3));
    idle_row();
    idle_row();
    append(r_type(op_sub, 5'd30, 5'd29, 5'd28));
    after_idles(r_type(op_add, 5'd1, 5'd30, 5'd2));
    after_idles(r_type(op_sub, 5'd2, 5'd1, 5'd5));
    after_idles(r_type(op_or, 5'd3, 5'd2, 5'd1));
    after_idles(imm_type(op_andi, 5'd5, 5'd3, 16'hffff));
    after_idles(shift_type(op_srl, 5'd6, 5'd5, 5'd7));
    // no writeback for r0, nop and undefined opcodes
    append(imm_type(op_addi, 5'd0, 5'd1, 16'h0005));
    append(r_type(op_add, 5'd31, 5'd0, 5'd1));
    append(r_type(op_nop, 5'd9, 5'd1, 5'd2));
    append(r_type(opcode_e'(6'd63), 5'd7, 5'd1, 5'd2));
    append(r_type(op_or, 5'd7, 5'd0, 5'd0));
    // full rate chain
    append(imm_type(op_addi, 5'd10, 5'd0, 16'h0001));
    append(r_type(op_add, 5'd11, 5'd10, 5'd10));
    append(r_type(op_add, 5'd12, 5'd11, 5'd10));
    append(shift_type(op_sll, 5'd13, 5'd12, 5'd2));
    append(r_type(op_sub, 5'd14, 5'd13, 5'd11));
    append(r_type(op_slt, 5'd17, 5'd14, 5'd13));
    append(imm_type(op_ori, 5'd18, 5'd17, 16'ha5a5));
    append(r_type(op_add, 5'd19, 5'd18, 5'd14));
  endtask

  always @(posedge clk) begin
    if (rst_n) begin
      cycle_cnt <= cycle_cnt + 1;
      if ((timeout_limit > 0) && (cycle_cnt >= timeout_limit)) begin
        $display("timeout: the run did not end within %0d cycles", timeout_limit);
        stop_on_error();
      end
    end
  end

  initial begin
    int idles;
    seed = 49;
    inst_valid = 1'b0;
    inst = '0;
    for (int k = 0; k < num_regs; k++) begin
      ref_regs[k] = '0;
    end
    build_table();
    timeout_limit = 2 * rows.size() + 40;
    // nothing retires in the first two cycles after reset
    pending.push_back('0);
    pending.push_back('0);
    wait (rst_n === 1'b1);
    repeat (2) step(1'b0, '0);
    foreach (rows[n]) begin
      if (rows[n].jitter) begin
        idles = {$random(seed)} % 4;
        repeat (idles) step(1'b0, '0);
      end
      step(!rows[n].gap, rows[n].inst);
    end
    repeat (2) step(1'b0, '0);
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* dv/tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk,
  output logic rst_n
);

  localparam int half_period  = 4;
  localparam int reset_cycles = 4;

  initial begin
    clk = 1'b0;
    forever #(half_period) clk = ~clk;
  end

  // reset released on a rising edge
  initial begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

`default_nettype wire

/* hw/cpu_core.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_core (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               inst_valid,
  input  cpu_isa_pkg::inst_t inst,
  output cpu_pipe_pkg::wb_t  wb
);

  import cpu_isa_pkg::*;
  import cpu_pipe_pkg::*;

  reg_addr_t rs_addr;
  reg_addr_t rt_addr;
  word_t     rs_data;
  word_t     rt_data;
  id_ex_t    id_ex;

  ////////////////////////////////////////////////////////////////////////////
  // decode and register read
  ////////////////////////////////////////////////////////////////////////////

  decode_unit i_decode (
    .clk        (clk),
    .rst_n      (rst_n),
    .inst_valid (inst_valid),
    .inst       (inst),
    .rs_addr    (rs_addr),
    .rt_addr    (rt_addr),
    .rs_data    (rs_data),
    .rt_data    (rt_data),
    .id_ex      (id_ex)
  );

  // written from the writeback register
  register_file i_regfile (
    .clk     (clk),
    .rst_n   (rst_n),
    .wb      (wb),
    .rs_addr (rs_addr),
    .rt_addr (rt_addr),
    .rs_data (rs_data),
    .rt_data (rt_data)
  );

  ////////////////////////////////////////////////////////////////////////////
  // execute and writeback
  ////////////////////////////////////////////////////////////////////////////

  execute_stage i_execute (
    .clk   (clk),
    .rst_n (rst_n),
    .id_ex (id_ex),
    .wb    (wb)
  );

endmodule

`default_nettype wire

/* hw/execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
  input  logic                 clk,
  input  logic                 rst_n,
  input  cpu_pipe_pkg::id_ex_t id_ex,
  output cpu_pipe_pkg::wb_t    wb
);

  import cpu_isa_pkg::*;
  import cpu_pipe_pkg::*;

  word_t op_a;
  word_t op_b_fwd;
  word_t op_b;
  word_t alu_result;
  wb_t   wb_d;

  ////////////////////////////////////////////////////////////////////////////
  // operand forwarding from the writeback register
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    op_a = id_ex.rs_data;
    if (wb.valid && (wb.rd == id_ex.rs)) begin
      op_a = wb.data;
    end
  end

  always_comb begin
    op_b_fwd = id_ex.rt_data;
    if (wb.valid && (wb.rd == id_ex.rt)) begin
      op_b_fwd = wb.data;
    end
  end

  // immediate overrides the forwarded rt
  assign op_b = id_ex.alu_src ? id_ex.imm : op_b_fwd;

  alu i_alu (
    .op     (id_ex.alu_op),
    .a      (op_a),
    .b      (op_b),
    .shamt  (id_ex.shamt),
    .result (alu_result)
  );

  ////////////////////////////////////////////////////////////////////////////
  // execute to writeback register
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    wb_d.valid = id_ex.valid && id_ex.reg_write;
    wb_d.rd    = id_ex.dest;
    wb_d.data  = alu_result;
  end

  always_ff @(posedge clk) begin
    wb <= wb_d;
    if (!rst_n) begin
      wb.valid <= 1'b0;
    end
  end

  // decode gates reg_write on the destination
  a_wb_rd_nonzero: assert property (
    @(posedge clk) disable iff (!rst_n) wb.valid |-> (wb.rd != '0)
  );

endmodule

`default_nettype wire

/* hw/register_file.sv */
`timescale 1ns/1ps
`default_nettype none

module register_file (
  input  logic                   clk,
  input  logic                   rst_n,
  input  cpu_pipe_pkg::wb_t      wb,
  input  cpu_isa_pkg::reg_addr_t rs_addr,
  input  cpu_isa_pkg::reg_addr_t rt_addr,
  output cpu_isa_pkg::word_t     rs_data,
  output cpu_isa_pkg::word_t     rt_data
);

  import cpu_isa_pkg::*;

  word_t regs [num_regs];

  // r0 reads zero and a pending write passes straight through
  function automatic word_t read_port(input reg_addr_t addr);
    word_t value;
    if (addr == '0) begin
      value = '0;
    end else if (wb.valid && (wb.rd == addr)) begin
      value = wb.data;
    end else begin
      value = regs[addr];
    end
    return value;
  endfunction

  always_comb begin
    rs_data = read_port(rs_addr);
    rt_data = read_port(rt_addr);
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.valid) begin
      regs[wb.rd] <= wb.data;
    end
  end

  a_r0_zero: assert property (
    @(posedge clk) disable iff (!rst_n) regs[0] == '0
  );

endmodule

`default_nettype wire

/* hw/decode_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_unit (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   inst_valid,
  input  cpu_isa_pkg::inst_t     inst,
  output cpu_isa_pkg::reg_addr_t rs_addr,
  output cpu_isa_pkg::reg_addr_t rt_addr,
  input  cpu_isa_pkg::word_t     rs_data,
  input  cpu_isa_pkg::word_t     rt_data,
  output cpu_pipe_pkg::id_ex_t   id_ex
);

  import cpu_isa_pkg::*;
  import cpu_pipe_pkg::*;

  alu_op_e   alu_op;
  logic      alu_src;
  logic      known;
  reg_addr_t dest;
  id_ex_t    id_ex_d;

  assign rs_addr = inst.rs;
  assign rt_addr = inst.rt;

  ////////////////////////////////////////////////////////////////////////////
  // control
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    alu_op  = alu_add;
    alu_src = 1'b0;
    known   = 1'b1;
    case (inst.opcode)
      op_add:  alu_op = alu_add;
      op_sub:  alu_op = alu_sub;
      op_and:  alu_op = alu_and;
      op_or:   alu_op = alu_or;
      op_xor:  alu_op = alu_xor;
      op_slt:  alu_op = alu_slt;
      op_sll:  alu_op = alu_sll;
      op_srl:  alu_op = alu_srl;
      op_addi: begin
        alu_op  = alu_add;
        alu_src = 1'b1;
      end
      op_andi: begin
        alu_op  = alu_and;
        alu_src = 1'b1;
      end
      op_ori: begin
        alu_op  = alu_or;
        alu_src = 1'b1;
      end
      // nop and undefined opcodes
      default: known = 1'b0;
    endcase
  end

  // i-type writes rt
  assign dest = alu_src ? inst.rt : inst.low.r.rd;

  always_comb begin
    id_ex_d.valid     = inst_valid;
    id_ex_d.alu_op    = alu_op;
    id_ex_d.alu_src   = alu_src;
    id_ex_d.reg_write = known && (dest != '0);
    id_ex_d.rs        = inst.rs;
    id_ex_d.rt        = inst.rt;
    id_ex_d.dest      = dest;
    id_ex_d.shamt     = inst.low.r.shamt;
    id_ex_d.imm       = {{(xlen-imm_w){1'b0}}, inst.low.imm};
    id_ex_d.rs_data   = rs_data;
    id_ex_d.rt_data   = rt_data;
  end

  always_ff @(posedge clk) begin
    id_ex <= id_ex_d;
    if (!rst_n) begin
      id_ex.valid <= 1'b0;
    end
  end

  a_opcode_known: assert property (
    @(posedge clk) disable iff (!rst_n) inst_valid |-> !$isunknown(inst.opcode)
  );

endmodule

`default_nettype wire

/* hw/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  cpu_pipe_pkg::alu_op_e op,
  input  cpu_isa_pkg::word_t    a,
  input  cpu_isa_pkg::word_t    b,
  input  logic [4:0]            shamt,
  output cpu_isa_pkg::word_t    result
);

  import cpu_isa_pkg::*;
  import cpu_pipe_pkg::*;

  logic lt;

  // signed compare for slt
  assign lt = $signed(a) < $signed(b);

  always_comb begin
    case (op)
      alu_add: result = a + b;
      alu_sub: result = a - b;
      alu_and: result = a & b;
      alu_or:  result = a | b;
      alu_xor: result = a ^ b;
      alu_slt: result = {{(xlen-1){1'b0}}, lt};
      // shifts act on the second operand
      alu_sll: result = b << shamt;
      alu_srl: result = b >> shamt;
      default: result = '0;
    endcase
  end

endmodule

`default_nettype wire

/* hw/cpu_pipe_pkg.sv */
`default_nettype none

package cpu_pipe_pkg;

  typedef enum logic [3:0] {
    alu_add = 4'd0,
    alu_sub = 4'd1,
    alu_and = 4'd2,
    alu_or  = 4'd3,
    alu_xor = 4'd4,
    alu_slt = 4'd5,
    alu_sll = 4'd6,
    alu_srl = 4'd7
  } alu_op_e;

  ////////////////////////////////////////////////////////////////////////////
  // stage registers
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic                  valid;
    alu_op_e               alu_op;
    logic                  alu_src;
    logic                  reg_write;
    cpu_isa_pkg::reg_addr_t rs;
    cpu_isa_pkg::reg_addr_t rt;
    cpu_isa_pkg::reg_addr_t dest;
    logic [4:0]            shamt;
    cpu_isa_pkg::word_t    imm;
    cpu_isa_pkg::word_t    rs_data;
    cpu_isa_pkg::word_t    rt_data;
  } id_ex_t;

  // one retired register write
  typedef struct packed {
    logic                  valid;
    cpu_isa_pkg::reg_addr_t rd;
    cpu_isa_pkg::word_t    data;
  } wb_t;

endpackage

`default_nettype wire

/* hw/cpu_isa_pkg.sv */
`default_nettype none

package cpu_isa_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;
  localparam int num_regs   = 32;
  localparam int imm_w      = 16;
  localparam int opcode_w   = 6;
  localparam int shamt_w    = 5;
  localparam int funct_w    = 6;

  typedef logic [xlen-1:0]       word_t;
  typedef logic [reg_addr_w-1:0] reg_addr_t;

  // anything outside this list decodes as undefined
  typedef enum logic [opcode_w-1:0] {
    op_nop  = 6'd0,
    op_add  = 6'd1,
    op_sub  = 6'd2,
    op_and  = 6'd3,
    op_or   = 6'd4,
    op_xor  = 6'd5,
    op_slt  = 6'd6,
    op_sll  = 6'd7,
    op_srl  = 6'd8,
    op_addi = 6'd9,
    op_andi = 6'd10,
    op_ori  = 6'd11
  } opcode_e;

  ////////////////////////////////////////////////////////////////////////////
  // instruction format
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    reg_addr_t          rd;
    logic [shamt_w-1:0] shamt;
    logic [funct_w-1:0] funct;
  } r_fields_t;

  // low half is either rd/shamt/funct or the immediate
  typedef union packed {
    r_fields_t        r;
    logic [imm_w-1:0] imm;
  } low_t;

  typedef struct packed {
    opcode_e   opcode;
    reg_addr_t rs;
    reg_addr_t rt;
    low_t      low;
  } inst_t;

endpackage

`default_nettype wire
